// ==== tb.f ====
design/ooo_pkg.sv
design/dispatch_unit.sv
design/alu_unit.sv
design/mem_unit.sv
design/reorder_buffer.sv
design/ooo_core.sv
sim/ooo_core_asserts.sv
sim/tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the core and its testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ooo_core -f tb.f -o tb_ooo_core \
	&& ./obj_dir/tb_ooo_core | tee /dev/stderr | grep -qx "Verification passed" \
	&& echo "Simulation run: PASS" \
	|| { echo "Simulation run: FAIL"; exit 1; }

// ==== sim/tb_ooo_core.sv ====
/* Testbench for the out-of-order core. Feeds random decoded programs, runs each accepted
   instruction through a sequential model and checks every commit and the final registers */
`timescale 1ns/1ps

module tb_ooo_core;

	localparam int ALU_LEN     = 200;
	localparam int MIX_LEN     = 200;
	localparam int BURST_LEN   = 60;
	localparam int CYCLE_LIMIT = 20 * (ALU_LEN + MIX_LEN + BURST_LEN) + 200;

	logic                            clk = 1'b0;
	logic                            reset;
	logic                            inst_valid;
	ooo_pkg::decoded_t               inst;
	logic                            inst_last;
	logic                            stall;
	ooo_pkg::commit_t                commit;
	logic [ooo_pkg::ARCH_ADDR_W-1:0] arch_addr;
	logic [ooo_pkg::XLEN-1:0]        arch_data;
	logic                            finish;

	logic [ooo_pkg::XLEN-1:0]  model_regs [ooo_pkg::NUM_ARCH_REGS];
	logic [ooo_pkg::XLEN-1:0]  model_mem  [ooo_pkg::DMEM_WORDS];
	logic [ooo_pkg::TAG_W-1:0] model_tag;
	ooo_pkg::commit_t          expected_q [$];
	logic                      stall_seen;
	int                        error_count    = 0;
	int                        checks         = 0;
	int                        tests_run      = 0;
	int                        tests_failed   = 0;
	int                        accepted_count = 0;
	int                        commit_count   = 0;
	int                        cycle_count    = 0;

	always #4 clk = ~clk;

	bind ooo_core ooo_core_asserts asserts0 (
		.clk        (clk),
		.reset      (reset),
		.commit     (commit),
		.rob_empty  (rob_empty),
		.alu_result (alu_result),
		.mem_result (mem_result)
	);

	ooo_core dut0 (
		.clk        (clk),
		.reset      (reset),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_last  (inst_last),
		.stall      (stall),
		.commit     (commit),
		.arch_addr  (arch_addr),
		.arch_data  (arch_data),
		.finish     (finish)
	);

	task automatic check_commit(input ooo_pkg::commit_t got, input ooo_pkg::commit_t exp);
		checks++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0t: commit tag %0d dest %0d/%0b value %h, expected %0d %0d/%0b %h",
				$time, got.tag, got.dest, got.has_dest, got.value,
				exp.tag, exp.dest, exp.has_dest, exp.value);
		end
	endtask

	task automatic check_reg(input logic [ooo_pkg::ARCH_ADDR_W-1:0] r,
		input logic [ooo_pkg::XLEN-1:0] got, input logic [ooo_pkg::XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0t: register %0d reads %h, expected %h", $time, r, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			error_count++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Runs one instruction in program order and returns the retirement it must produce
	function automatic ooo_pkg::commit_t execute_model(input ooo_pkg::decoded_t d);
		ooo_pkg::commit_t         c;
		logic [ooo_pkg::XLEN-1:0] a;
		logic [ooo_pkg::XLEN-1:0] b;
		logic [ooo_pkg::XLEN-1:0] ea;
		a  = model_regs[d.src1];
		b  = d.use_imm ? d.imm : model_regs[d.src2];
		ea = a + d.imm;
		c.valid    = 1'b1;
		c.tag      = model_tag;
		c.has_dest = (d.op != ooo_pkg::OP_SW);
		c.dest     = d.dest;
		c.value    = '0;
		case (d.op)
			ooo_pkg::OP_ADD: c.value = a + b;
			ooo_pkg::OP_SUB: c.value = a - b;
			ooo_pkg::OP_AND: c.value = a & b;
			ooo_pkg::OP_OR:  c.value = a | b;
			ooo_pkg::OP_XOR: c.value = a ^ b;
			ooo_pkg::OP_SLL: c.value = a << b[4:0];
			ooo_pkg::OP_LW:  c.value = model_mem[ea[ooo_pkg::DMEM_ADDR_W-1:0]];
			default:         model_mem[ea[ooo_pkg::DMEM_ADDR_W-1:0]] = model_regs[d.src2];
		endcase
		if (c.has_dest) begin
			model_regs[d.dest] = c.value;
		end
		model_tag = model_tag + 1'b1;
		return c;
	endfunction

	// A small register span gives long dependency chains
	function automatic ooo_pkg::decoded_t random_alu(input int span);
		ooo_pkg::decoded_t d;
		d.op      = ooo_pkg::op_t'($urandom_range(0, 5));
		d.dest    = ooo_pkg::ARCH_ADDR_W'($urandom_range(0, span - 1));
		d.src1    = ooo_pkg::ARCH_ADDR_W'($urandom_range(0, span - 1));
		d.src2    = ooo_pkg::ARCH_ADDR_W'($urandom_range(0, span - 1));
		d.use_imm = 1'($urandom_range(0, 1));
		d.imm     = $urandom();
		return d;
	endfunction

	function automatic ooo_pkg::decoded_t random_mem(input ooo_pkg::op_t op);
		ooo_pkg::decoded_t d;
		d.op      = op;
		d.dest    = ooo_pkg::ARCH_ADDR_W'($urandom_range(0, 7));
		d.src1    = ooo_pkg::ARCH_ADDR_W'($urandom_range(0, 7));
		d.src2    = ooo_pkg::ARCH_ADDR_W'($urandom_range(0, 7));
		d.use_imm = 1'b1;
		d.imm     = $urandom_range(0, ooo_pkg::DMEM_WORDS - 1);
		return d;
	endfunction

	// Holds the instruction until a cycle without stall, then it is taken at the next edge
	task automatic send_inst(input ooo_pkg::decoded_t d, input logic last);
		@(posedge clk);
		#1;
		inst       = d;
		inst_last  = last;
		inst_valid = 1'b1;
		@(negedge clk);
		while (stall) begin
			stall_seen = 1'b1;
			@(negedge clk);
		end
		expected_q.push_back(execute_model(d));
		accepted_count++;
	endtask

	task automatic drain();
		@(posedge clk);
		#1;
		inst_valid = 1'b0;
		inst_last  = 1'b0;
		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic read_reg(input int r, input logic [ooo_pkg::XLEN-1:0] exp);
		@(posedge clk);
		#1;
		arch_addr = ooo_pkg::ARCH_ADDR_W'(r);
		@(negedge clk);
		check_reg(arch_addr, arch_data, exp);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("Test %s: done, no errors", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, error_count - errs_before);
		end
	endtask

	always @(negedge clk) begin
		if (!reset && commit.valid) begin
			commit_count++;
			if (expected_q.size() == 0) begin
				error_count++;
				$display("Error at %0t: tag %0d committed with nothing outstanding", $time,
					commit.tag);
			end else begin
				check_commit(commit, expected_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		ooo_pkg::decoded_t d;
		int                errs;
		int                k;
		int                acc0;
		int                com0;
		logic [2:0]        prev;
		void'($urandom(12299));
		reset      = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		inst_last  = 1'b0;
		arch_addr  = '0;
		model_tag  = '0;
		stall_seen = 1'b0;
		for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < ooo_pkg::DMEM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		errs = error_count;
		@(negedge clk);
		check_flag("stall after reset", stall, 1'b0);
		check_flag("commit.valid after reset", commit.valid, 1'b0);
		check_flag("finish after reset", finish, 1'b0);
		for (int r = 0; r < ooo_pkg::NUM_ARCH_REGS; r++) begin
			read_reg(r, '0);
		end
		end_test("reset state", errs);

		errs = error_count;
		for (int i = 0; i < ALU_LEN; i++) begin
			send_inst(random_alu(4), 1'b0);
		end
		drain();
		end_test("ALU chain", errs);

		errs = error_count;
		k = 0;
		while (k < MIX_LEN) begin
			case ($urandom_range(0, 9))
				0, 1, 2: begin
					send_inst(random_mem(ooo_pkg::OP_LW), 1'b0);
					k++;
				end
				3, 4, 5: begin
					d = random_mem(ooo_pkg::OP_SW);
					send_inst(d, 1'b0);
					// The load reuses the store's base and offset and reads back its word
					d.op = ooo_pkg::OP_LW;
					send_inst(d, 1'b0);
					k += 2;
				end
				default: begin
					send_inst(random_alu(8), 1'b0);
					k++;
				end
			endcase
		end
		drain();
		end_test("memory mix", errs);

		// Each load takes its base from the one before
		errs       = error_count;
		acc0       = accepted_count;
		com0       = commit_count;
		stall_seen = 1'b0;
		prev       = 3'd1;
		for (int i = 0; i < BURST_LEN; i++) begin
			d      = random_mem(ooo_pkg::OP_LW);
			d.src1 = prev;
			if (i % 6 == 5) begin
				d.op      = ooo_pkg::OP_ADD;
				d.use_imm = 1'b0;
			end
			prev = d.dest;
			send_inst(d, i == BURST_LEN - 1);
		end
		drain();
		check_flag("stall during burst", stall_seen, 1'b1);
		check_count("commits in burst", commit_count - com0, accepted_count - acc0);
		end_test("back-pressure burst", errs);

		errs = error_count;
		while (!finish) begin
			@(negedge clk);
		end
		repeat (4) begin
			@(negedge clk);
			check_flag("finish", finish, 1'b1);
		end
		for (int r = 0; r < ooo_pkg::NUM_ARCH_REGS; r++) begin
			read_reg(r, model_regs[r]);
		end
		check_flag("finish after readback", finish, 1'b1);
		end_test("finish and register file", errs);

		error_count += dut0.asserts0.fails;
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d, commits %0d",
			tests_run, tests_failed, checks, error_count, commit_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== sim/ooo_core_asserts.sv ====
/* Commit order and result-bus assertions for the out-of-order core.
   The testbench binds it into ooo_core and adds the fails count to its errors */
`timescale 1ns/1ps

module ooo_core_asserts (
	input logic             clk,
	input logic             reset,
	input ooo_pkg::commit_t commit,
	input logic             rob_empty,
	input ooo_pkg::result_t alu_result,
	input ooo_pkg::result_t mem_result
);

	logic [ooo_pkg::TAG_W-1:0] next_tag;
	int                        fails = 0;

	// Tag the next commit must carry
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			next_tag <= '0;
		end else if (commit.valid) begin
			next_tag <= next_tag + 1'b1;
		end
	end

	commit_in_order: assert property (@(posedge clk) disable iff (reset)
		commit.valid |-> commit.tag == next_tag)
		else begin
			fails++;
			$error("commit tag %0d where %0d was due", commit.tag, next_tag);
		end

	no_commit_when_empty: assert property (@(posedge clk) disable iff (reset)
		rob_empty |-> !commit.valid)
		else begin
			fails++;
			$error("commit while the ROB is empty");
		end

	distinct_bus_tags: assert property (@(posedge clk) disable iff (reset)
		(alu_result.valid && mem_result.valid) |-> alu_result.tag != mem_result.tag)
		else begin
			fails++;
			$error("both result buses carry tag %0d", alu_result.tag);
		end

endmodule

// ==== design/ooo_core.sv ====
/* Top level of the out-of-order core. Connects dispatch, the two execution units
   and the reorder buffer, and raises finish once the last instruction has retired */
`timescale 1ns/1ps

module ooo_core (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            inst_valid,
	input  ooo_pkg::decoded_t               inst,
	input  logic                            inst_last,
	output logic                            stall,
	output ooo_pkg::commit_t                commit,
	input  logic [ooo_pkg::ARCH_ADDR_W-1:0] arch_addr,
	output logic [ooo_pkg::XLEN-1:0]        arch_data,
	output logic                            finish
);

	logic                      rob_full;
	logic                      rob_empty;
	logic [ooo_pkg::TAG_W-1:0] rob_tail_tag;
	logic                      alloc_valid;
	logic [ooo_pkg::TAG_W-1:0] query_tag1;
	logic [ooo_pkg::TAG_W-1:0] query_tag2;
	logic                      query_done1;
	logic                      query_done2;
	logic [ooo_pkg::XLEN-1:0]  query_val1;
	logic [ooo_pkg::XLEN-1:0]  query_val2;
	logic                      alu_full;
	logic                      mem_full;
	logic                      alu_issue;
	logic                      mem_issue;
	ooo_pkg::issue_t           issue;
	ooo_pkg::result_t          alu_result;
	ooo_pkg::result_t          mem_result;
	logic                      last_seen;

	// Latches once the final instruction is accepted
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			last_seen <= 1'b0;
		end else if (inst_valid && !stall && inst_last) begin
			last_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			finish <= 1'b0;
		end else if (last_seen && rob_empty) begin
			finish <= 1'b1;
		end
	end

	dispatch_unit dispatch0 (
		.clk          (clk),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.stall        (stall),
		.rob_full     (rob_full),
		.rob_tail_tag (rob_tail_tag),
		.alloc_valid  (alloc_valid),
		.query_tag1   (query_tag1),
		.query_tag2   (query_tag2),
		.query_done1  (query_done1),
		.query_done2  (query_done2),
		.query_val1   (query_val1),
		.query_val2   (query_val2),
		.alu_full     (alu_full),
		.mem_full     (mem_full),
		.alu_issue    (alu_issue),
		.mem_issue    (mem_issue),
		.issue        (issue),
		.alu_result   (alu_result),
		.mem_result   (mem_result),
		.retire       (commit),
		.arch_addr    (arch_addr),
		.arch_data    (arch_data)
	);

	alu_unit alu0 (
		.clk        (clk),
		.reset      (reset),
		.alu_issue  (alu_issue),
		.issue      (issue),
		.alu_full   (alu_full),
		.alu_result (alu_result),
		.mem_result (mem_result)
	);

	mem_unit mem0 (
		.clk        (clk),
		.reset      (reset),
		.mem_issue  (mem_issue),
		.issue      (issue),
		.mem_full   (mem_full),
		.mem_result (mem_result),
		.alu_result (alu_result)
	);

	// Stores are the only operations without a destination
	reorder_buffer rob0 (
		.clk            (clk),
		.reset          (reset),
		.alloc_valid    (alloc_valid),
		.alloc_dest     (inst.dest),
		.alloc_has_dest (inst.op != ooo_pkg::OP_SW),
		.rob_tail_tag   (rob_tail_tag),
		.rob_full       (rob_full),
		.rob_empty      (rob_empty),
		.alu_result     (alu_result),
		.mem_result     (mem_result),
		.query_tag1     (query_tag1),
		.query_tag2     (query_tag2),
		.query_done1    (query_done1),
		.query_done2    (query_done2),
		.query_val1     (query_val1),
		.query_val2     (query_val2),
		.retire         (commit)
	);

endmodule

// ==== design/reorder_buffer.sv ====
/* Eight-entry reorder buffer. Hands out tags at dispatch, marks entries done from
   both result buses, answers operand queries and retires the head in order */
`timescale 1ns/1ps

module reorder_buffer (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            alloc_valid,
	input  logic [ooo_pkg::ARCH_ADDR_W-1:0] alloc_dest,
	input  logic                            alloc_has_dest,
	output logic [ooo_pkg::TAG_W-1:0]       rob_tail_tag,
	output logic                            rob_full,
	output logic                            rob_empty,
	input  ooo_pkg::result_t                alu_result,
	input  ooo_pkg::result_t                mem_result,
	input  logic [ooo_pkg::TAG_W-1:0]       query_tag1,
	input  logic [ooo_pkg::TAG_W-1:0]       query_tag2,
	output logic                            query_done1,
	output logic                            query_done2,
	output logic [ooo_pkg::XLEN-1:0]        query_val1,
	output logic [ooo_pkg::XLEN-1:0]        query_val2,
	output ooo_pkg::commit_t                retire
);

	logic [ooo_pkg::ROB_DEPTH-1:0]   valid;
	logic [ooo_pkg::ROB_DEPTH-1:0]   done;
	logic [ooo_pkg::ROB_DEPTH-1:0]   has_dest;
	logic [ooo_pkg::ARCH_ADDR_W-1:0] dest  [ooo_pkg::ROB_DEPTH];
	logic [ooo_pkg::XLEN-1:0]        value [ooo_pkg::ROB_DEPTH];
	logic [ooo_pkg::TAG_W-1:0]       head;
	logic [ooo_pkg::TAG_W-1:0]       tail;
	logic [ooo_pkg::TAG_W:0]         count;
	logic                            fire;

	assign rob_tail_tag = tail;
	assign rob_full     = (count == ooo_pkg::ROB_DEPTH);
	assign rob_empty    = (count == '0);

	// Done stays set after retirement until the slot is handed out again
	assign query_done1 = done[query_tag1];
	assign query_done2 = done[query_tag2];
	assign query_val1  = value[query_tag1];
	assign query_val2  = value[query_tag2];

	assign fire = valid[head] && done[head];

	always_comb begin
		retire.valid    = fire;
		retire.tag      = head;
		retire.has_dest = has_dest[head];
		retire.dest     = dest[head];
		retire.value    = value[head];
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid <= '0;
			done  <= '0;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (alu_result.valid) begin
				done[alu_result.tag] <= 1'b1;
			end
			if (mem_result.valid) begin
				done[mem_result.tag] <= 1'b1;
			end
			if (fire) begin
				valid[head] <= 1'b0;
				head        <= head + 1'b1;
			end
			if (alloc_valid) begin
				valid[tail] <= 1'b1;
				done[tail]  <= 1'b0;
				tail        <= tail + 1'b1;
			end
			count <= count + (ooo_pkg::TAG_W + 1)'(alloc_valid)
				- (ooo_pkg::TAG_W + 1)'(fire);
		end
	end

	always_ff @(posedge clk) begin
		if (alu_result.valid) begin
			value[alu_result.tag] <= alu_result.value;
		end
		if (mem_result.valid) begin
			value[mem_result.tag] <= mem_result.value;
		end
		if (alloc_valid) begin
			dest[tail]     <= alloc_dest;
			has_dest[tail] <= alloc_has_dest;
		end
	end

endmodule

// ==== design/mem_unit.sv ====
/* Memory unit with an in-order load/store queue and a 16-word data memory.
   The head starts once its operands are in, then address and access take a cycle each */
`timescale 1ns/1ps

module mem_unit (
	input  logic             clk,
	input  logic             reset,
	input  logic             mem_issue,
	input  ooo_pkg::issue_t  issue,
	output logic             mem_full,
	output ooo_pkg::result_t mem_result,
	input  ooo_pkg::result_t alu_result
);

	ooo_pkg::issue_t                  mq   [ooo_pkg::MQ_DEPTH];
	logic [ooo_pkg::XLEN-1:0]         dmem [ooo_pkg::DMEM_WORDS];
	logic [ooo_pkg::MQ_DEPTH-1:0]     valid;
	logic [ooo_pkg::MQ_IDX_W-1:0]     head;
	logic [ooo_pkg::MQ_IDX_W-1:0]     tail;
	logic                             start;
	logic [ooo_pkg::XLEN-1:0]         addr_sum;
	// Address stage
	logic                             s1_valid;
	logic                             s1_store;
	logic [ooo_pkg::TAG_W-1:0]        s1_tag;
	logic [ooo_pkg::DMEM_ADDR_W-1:0]  s1_addr;
	logic [ooo_pkg::XLEN-1:0]         s1_data;

	assign mem_full = valid[tail];
	// Loads arrive with src2 already marked ready
	assign start    = valid[head] && mq[head].src1.ready && mq[head].src2.ready;
	assign addr_sum = mq[head].src1.value + mq[head].imm;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid      <= '0;
			head       <= '0;
			tail       <= '0;
			s1_valid   <= 1'b0;
			mem_result <= '0;
			for (int i = 0; i < ooo_pkg::DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else begin
			if (start) begin
				valid[head] <= 1'b0;
				head        <= head + 1'b1;
			end
			if (mem_issue) begin
				valid[tail] <= 1'b1;
				tail        <= tail + 1'b1;
			end
			s1_valid <= start;
			// A store reports value 0 in the access stage to close its ROB entry
			mem_result.valid <= s1_valid;
			mem_result.tag   <= s1_tag;
			mem_result.value <= s1_store ? '0 : dmem[s1_addr];
			if (s1_valid && s1_store) begin
				dmem[s1_addr] <= s1_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < ooo_pkg::MQ_DEPTH; i++) begin
			mq[i].src1 <= ooo_pkg::snoop(mq[i].src1, alu_result, mem_result);
			mq[i].src2 <= ooo_pkg::snoop(mq[i].src2, alu_result, mem_result);
		end
		if (mem_issue) begin
			mq[tail] <= issue;
		end
		s1_store <= (mq[head].op == ooo_pkg::OP_SW);
		s1_tag   <= mq[head].tag;
		s1_addr  <= addr_sum[ooo_pkg::DMEM_ADDR_W-1:0];
		s1_data  <= mq[head].src2.value;
	end

endmodule

// ==== design/alu_unit.sv ====
/* ALU execution unit with a four-entry reservation station.
   Entries snoop both result buses, the lowest ready entry issues each cycle */
`timescale 1ns/1ps

module alu_unit (
	input  logic             clk,
	input  logic             reset,
	input  logic             alu_issue,
	input  ooo_pkg::issue_t  issue,
	output logic             alu_full,
	output ooo_pkg::result_t alu_result,
	input  ooo_pkg::result_t mem_result
);

	ooo_pkg::issue_t                rs [ooo_pkg::RS_DEPTH];
	logic [ooo_pkg::RS_DEPTH-1:0]   valid;
	logic [ooo_pkg::RS_DEPTH-1:0]   ready;
	logic [ooo_pkg::RS_IDX_W-1:0]   free_idx;
	logic [ooo_pkg::RS_IDX_W-1:0]   sel_idx;
	logic                           sel_valid;
	ooo_pkg::issue_t                sel;
	logic [ooo_pkg::XLEN-1:0]       opb;
	logic [ooo_pkg::XLEN-1:0]       res;

	assign alu_full = &valid;

	// Walk downwards so the lowest index wins
	always_comb begin
		free_idx  = '0;
		sel_idx   = '0;
		sel_valid = 1'b0;
		for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
			ready[i] = valid[i] && rs[i].src1.ready && rs[i].src2.ready;
			if (!valid[i]) begin
				free_idx = ooo_pkg::RS_IDX_W'(i);
			end
			if (ready[i]) begin
				sel_idx   = ooo_pkg::RS_IDX_W'(i);
				sel_valid = 1'b1;
			end
		end
	end

	assign sel = rs[sel_idx];
	assign opb = sel.use_imm ? sel.imm : sel.src2.value;

	always_comb begin
		case (sel.op)
			ooo_pkg::OP_ADD: res = sel.src1.value + opb;
			ooo_pkg::OP_SUB: res = sel.src1.value - opb;
			ooo_pkg::OP_AND: res = sel.src1.value & opb;
			ooo_pkg::OP_OR:  res = sel.src1.value | opb;
			ooo_pkg::OP_XOR: res = sel.src1.value ^ opb;
			ooo_pkg::OP_SLL: res = sel.src1.value << opb[4:0];
			default:         res = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid      <= '0;
			alu_result <= '0;
		end else begin
			if (sel_valid) begin
				valid[sel_idx] <= 1'b0;
			end
			if (alu_issue) begin
				valid[free_idx] <= 1'b1;
			end
			alu_result.valid <= sel_valid;
			alu_result.tag   <= sel.tag;
			alu_result.value <= res;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
			rs[i].src1 <= ooo_pkg::snoop(rs[i].src1, alu_result, mem_result);
			rs[i].src2 <= ooo_pkg::snoop(rs[i].src2, alu_result, mem_result);
		end
		if (alu_issue) begin
			rs[free_idx] <= issue;
		end
	end

endmodule

// ==== design/dispatch_unit.sv ====
/* Rename and dispatch stage with the committed register file and status table.
   Resolves both sources, allocates a ROB tag and routes to the ALU or memory unit */
`timescale 1ns/1ps

module dispatch_unit (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            inst_valid,
	input  ooo_pkg::decoded_t               inst,
	output logic                            stall,
	input  logic                            rob_full,
	input  logic [ooo_pkg::TAG_W-1:0]       rob_tail_tag,
	output logic                            alloc_valid,
	output logic [ooo_pkg::TAG_W-1:0]       query_tag1,
	output logic [ooo_pkg::TAG_W-1:0]       query_tag2,
	input  logic                            query_done1,
	input  logic                            query_done2,
	input  logic [ooo_pkg::XLEN-1:0]        query_val1,
	input  logic [ooo_pkg::XLEN-1:0]        query_val2,
	input  logic                            alu_full,
	input  logic                            mem_full,
	output logic                            alu_issue,
	output logic                            mem_issue,
	output ooo_pkg::issue_t                 issue,
	input  ooo_pkg::result_t                alu_result,
	input  ooo_pkg::result_t                mem_result,
	input  ooo_pkg::commit_t                retire,
	input  logic [ooo_pkg::ARCH_ADDR_W-1:0] arch_addr,
	output logic [ooo_pkg::XLEN-1:0]        arch_data
);

	logic [ooo_pkg::XLEN-1:0]          regs     [ooo_pkg::NUM_ARCH_REGS];
	logic [ooo_pkg::TAG_W-1:0]         stat_tag [ooo_pkg::NUM_ARCH_REGS];
	logic [ooo_pkg::NUM_ARCH_REGS-1:0] busy;
	logic                              is_mem;
	logic                              need_src2;
	logic                              accept;

	// Register file first, then a done ROB entry, then a bus in this cycle
	function automatic ooo_pkg::operand_t lookup(
		input logic [ooo_pkg::ARCH_ADDR_W-1:0] src,
		input logic                            done,
		input logic [ooo_pkg::XLEN-1:0]        val
	);
		ooo_pkg::operand_t opnd;
		opnd.tag   = stat_tag[src];
		opnd.ready = 1'b1;
		if (!busy[src]) begin
			opnd.value = regs[src];
		end else if (done) begin
			opnd.value = val;
		end else begin
			opnd.ready = 1'b0;
			opnd.value = '0;
			opnd = ooo_pkg::snoop(opnd, alu_result, mem_result);
		end
		return opnd;
	endfunction

	assign is_mem    = (inst.op == ooo_pkg::OP_LW) || (inst.op == ooo_pkg::OP_SW);
	// Loads and immediate ALU forms never wait on src2
	assign need_src2 = (inst.op == ooo_pkg::OP_SW) || (!is_mem && !inst.use_imm);

	assign stall       = rob_full || (is_mem ? mem_full : alu_full);
	assign accept      = inst_valid && !stall;
	assign alloc_valid = accept;
	assign alu_issue   = accept && !is_mem;
	assign mem_issue   = accept && is_mem;

	assign query_tag1 = stat_tag[inst.src1];
	assign query_tag2 = stat_tag[inst.src2];
	assign arch_data  = regs[arch_addr];

	always_comb begin
		issue.op      = inst.op;
		issue.tag     = rob_tail_tag;
		issue.use_imm = inst.use_imm;
		issue.imm     = inst.imm;
		issue.src1    = lookup(inst.src1, query_done1, query_val1);
		if (need_src2) begin
			issue.src2 = lookup(inst.src2, query_done2, query_val2);
		end else begin
			issue.src2 = '{ready: 1'b1, tag: '0, value: '0};
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= '0;
			for (int i = 0; i < ooo_pkg::NUM_ARCH_REGS; i++) begin
				regs[i]     <= '0;
				stat_tag[i] <= '0;
			end
		end else begin
			if (retire.valid && retire.has_dest) begin
				regs[retire.dest] <= retire.value;
				// A younger producer keeps the register pending
				if (stat_tag[retire.dest] == retire.tag) begin
					busy[retire.dest] <= 1'b0;
				end
			end
			// New producer wins over a clear in the same cycle
			if (accept && inst.op != ooo_pkg::OP_SW) begin
				busy[inst.dest]     <= 1'b1;
				stat_tag[inst.dest] <= rob_tail_tag;
			end
		end
	end

endmodule

// ==== design/ooo_pkg.sv ====
/* Sizes, opcodes and bundles shared by the out-of-order core and its testbench.
   Also holds the result-bus snoop that every waiting operand goes through */
package ooo_pkg;

	localparam int XLEN          = 32;
	localparam int NUM_ARCH_REGS = 8;
	localparam int ARCH_ADDR_W   = 3;
	localparam int ROB_DEPTH     = 8;
	localparam int TAG_W         = 3;
	localparam int RS_DEPTH      = 4;
	localparam int RS_IDX_W      = 2;
	localparam int MQ_DEPTH      = 4;
	localparam int MQ_IDX_W      = 2;
	localparam int DMEM_WORDS    = 16;
	localparam int DMEM_ADDR_W   = 4;

	// First six are ALU operations
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_LW,
		OP_SW
	} op_t;

	typedef struct packed {
		op_t                    op;
		logic [ARCH_ADDR_W-1:0] dest;
		logic [ARCH_ADDR_W-1:0] src1;
		logic [ARCH_ADDR_W-1:0] src2;
		logic                   use_imm;
		logic [XLEN-1:0]        imm;
	} decoded_t;

	// Waits on tag while ready is clear
	typedef struct packed {
		logic             ready;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  value;
	} operand_t;

	typedef struct packed {
		op_t              op;
		logic [TAG_W-1:0] tag;
		logic             use_imm;
		logic [XLEN-1:0]  imm;
		operand_t         src1;
		operand_t         src2;
	} issue_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  value;
	} result_t;

	typedef struct packed {
		logic                   valid;
		logic [TAG_W-1:0]       tag;
		logic                   has_dest;
		logic [ARCH_ADDR_W-1:0] dest;
		logic [XLEN-1:0]        value;
	} commit_t;

	// Capture a waiting operand from whichever bus carries its tag
	function automatic operand_t snoop(operand_t opnd, result_t a, result_t b);
		operand_t upd;
		upd = opnd;
		if (!opnd.ready && a.valid && a.tag == opnd.tag) begin
			upd.ready = 1'b1;
			upd.value = a.value;
		end else if (!opnd.ready && b.valid && b.tag == opnd.tag) begin
			upd.ready = 1'b1;
			upd.value = b.value;
		end
		return upd;
	endfunction

endpackage
